// File: dv/axil_mem_model.sv
/*
 * Behavioral AXI-Lite slave with 16 words at 0x43C00000, cleared by reset.
 * Serves one write and one read at a time and expects word aligned addresses.
 * Outside the window it answers DECERR, and reads there return 0.
 */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model (
    input  logic                       clock,
    input  logic                       arst_n,
    input  axis_bridge_pkg::axil_req_t req,
    output axis_bridge_pkg::axil_rsp_t rsp
);

    import axis_bridge_pkg::*;

    localparam logic [31:0] base = 32'h43C0_0000;
    localparam logic [31:0] span = 32'd64;

    logic [31:0] mem [16];
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic        aw_got;
    logic        w_got;
    // Cycles left before the matching ready is raised
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic [1:0]  ar_wait;
    integer      seed = 44;

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rsp     <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            aw_wait <= 2'd0;
            w_wait  <= 2'd0;
            ar_wait <= 2'd0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // Each ready rises after a random wait of 0 to 3 cycles and drops after its handshake
            if (req.awvalid && !aw_got && !rsp.awready) begin
                if (aw_wait == 2'd0) rsp.awready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end else begin
                rsp.awready <= 1'b0;
                aw_wait     <= 2'($random(seed));
            end
            if (req.wvalid && !w_got && !rsp.wready) begin
                if (w_wait == 2'd0) rsp.wready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end else begin
                rsp.wready <= 1'b0;
                w_wait     <= 2'($random(seed));
            end
            if (req.arvalid && !rsp.rvalid && !rsp.arready) begin
                if (ar_wait == 2'd0) rsp.arready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end else begin
                rsp.arready <= 1'b0;
                ar_wait     <= 2'($random(seed));
            end

            if (req.awvalid && rsp.awready) begin
                aw_addr <= req.awaddr;
                aw_got  <= 1'b1;
            end
            if (req.wvalid && rsp.wready) begin
                w_data <= req.wdata;
                w_got  <= 1'b1;
            end

            // The write lands once both address and data are in
            if (aw_got && w_got && !rsp.bvalid) begin
                rsp.bvalid <= 1'b1;
                if ((aw_addr - base) < span) begin
                    mem[aw_addr[5:2]] <= w_data;
                    rsp.bresp         <= OKAY;
                end else begin
                    rsp.bresp <= DECERR;
                end
            end
            if (rsp.bvalid && req.bready) begin
                rsp.bvalid <= 1'b0;
                aw_got     <= 1'b0;
                w_got      <= 1'b0;
            end

            if (req.arvalid && rsp.arready) begin
                rsp.rvalid <= 1'b1;
                if ((req.araddr - base) < span) begin
                    rsp.rdata <= mem[req.araddr[5:2]];
                    rsp.rresp <= OKAY;
                end else begin
                    rsp.rdata <= '0;
                    rsp.rresp <= DECERR;
                end
            end else if (rsp.rvalid && req.rready) begin
                rsp.rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/axis_to_axil_input.txt
// Columns in hex: op addr data resp. Op 1 write, 2 read expecting data and resp,
// 3 addr random writes in the window, 4 read all 16 window words, 5 hold response ready low addr cycles
1 43C00000 DEADBEEF 0
2 43C00000 DEADBEEF 0
2 43C00010 00000000 0
1 43C00100 12345678 3
2 50000000 00000000 3
5 0000001E 00000000 0
1 43C00004 11111111 0
2 43C00004 11111111 0
1 43C00008 22222222 0
2 43C00008 22222222 0
2 43C00000 DEADBEEF 0
1 43C00004 33333333 0
2 43C00004 33333333 0
2 43C0000C 00000000 0
3 0000000A 00000000 0
4 00000000 00000000 0

// File: dv/axis_to_axil_tb.sv
/*
 * Testbench for the stream to AXI-Lite bridge, driven by dv/axis_to_axil_input.txt.
 * Must run from the project root, and all addresses in the input are word aligned.
 */
`timescale 1ns/1ps
`default_nettype none

module axis_to_axil_tb;

    import axis_bridge_pkg::*;

    localparam logic [31:0] win_base  = 32'h43C0_0000;
    localparam int          win_words = 16;

    logic          clock = 1'b0;
    logic          arst_n = 1'b0;
    logic          wr_valid = 1'b0;
    logic          wr_ready;
    axis_wr_t      wr_beat = '0;
    logic          rq_valid = 1'b0;
    logic          rq_ready;
    axis_rd_req_t  rq_beat = '0;
    logic          rsp_valid;
    logic          rsp_ready = 1'b1;
    axis_rd_resp_t rsp_beat;
    axil_req_t     bus_req;
    axil_rsp_t     bus_rsp;
    logic          write_error;

    // Shadow of the slave memory that is updated when a write is accepted
    logic [31:0]   ref_mem [win_words];
    logic [31:0]   op_q [$];
    logic [31:0]   addr_q [$];
    logic [31:0]   data_q [$];
    logic [31:0]   resp_q [$];
    // Outstanding commands in acceptance order
    bit            exp_is_wr [$];
    axis_rd_resp_t exp_rsp [$];
    string         exp_name [$];
    int            read_errors = 0;
    int            write_errors = 0;
    int            other_errors = 0;
    int            cycles = 0;
    int            limit = 0;
    int            stall_until = 0;
    integer        seed = 44;

    always #5 clock = ~clock;

    axis_to_axil UUT (
        .clock                    (clock),
        .arst_n                   (arst_n),
        .axis_write_valid         (wr_valid),
        .axis_write_ready         (wr_ready),
        .axis_write               (wr_beat),
        .axis_read_request_valid  (rq_valid),
        .axis_read_request_ready  (rq_ready),
        .axis_read_request        (rq_beat),
        .axis_read_response_valid (rsp_valid),
        .axis_read_response_ready (rsp_ready),
        .axis_read_response       (rsp_beat),
        .axil_out                 (bus_req),
        .axil_in                  (bus_rsp),
        .write_error              (write_error)
    );

    axil_mem_model u_mem (
        .clock  (clock),
        .arst_n (arst_n),
        .req    (bus_req),
        .rsp    (bus_rsp)
    );

    function automatic logic in_window(input logic [31:0] addr);
        return (addr - win_base) < 32'(win_words * 4);
    endfunction

    // Last word written there, or 0, and OKAY only inside the window
    function automatic axis_rd_resp_t predict_read(input logic [31:0] addr);
        axis_rd_resp_t p;
        p.data = in_window(addr) ? ref_mem[addr[5:2]] : '0;
        p.resp = in_window(addr) ? OKAY : DECERR;
        return p;
    endfunction

    task automatic check_read(input string name, input axis_rd_resp_t expected,
                              input axis_rd_resp_t actual);
        if (actual !== expected) begin
            read_errors++;
            $display("MISMATCH %s expected data %h resp %0d actual data %h resp %0d",
                     name, expected.data, expected.resp, actual.data, actual.resp);
        end
    endtask

    task automatic check_write_err(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            write_errors++;
            $display("MISMATCH %s expected write_error %0b actual %0b", name, expected, actual);
        end
    endtask

    // Every write uses all four byte lanes and both protection fields stay zero
    task automatic check_tie_off(input string name, input axil_req_t actual);
        if (actual.wstrb !== 4'hF || actual.awprot !== 3'd0 || actual.arprot !== 3'd0) begin
            other_errors++;
            $display("MISMATCH %s expected strb f prot 0/0 actual strb %h prot %0d/%0d",
                     name, actual.wstrb, actual.awprot, actual.arprot);
        end
    endtask

    task automatic check_quiet(input logic in_reset);
        if (rsp_valid || write_error || bus_req.awvalid || bus_req.wvalid || bus_req.arvalid ||
            bus_req.bready || bus_req.rready) begin
            other_errors++;
            $display("ERROR: an output valid or ready is high at cycle %0d before any input",
                     cycles);
        end
        if (in_reset && (wr_ready || rq_ready)) begin
            other_errors++;
            $display("ERROR: an input ready is high during reset at cycle %0d", cycles);
        end
    endtask

    task automatic load_input();
        int               fd;
        int               n_ops;
        int               stall_total;
        logic [8*128-1:0] text;
        logic [31:0]      f_op;
        logic [31:0]      f_addr;
        logic [31:0]      f_data;
        logic [31:0]      f_resp;
        n_ops = 0;
        stall_total = 0;
        fd = $fopen("dv/axis_to_axil_input.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: cannot open dv/axis_to_axil_input.txt");
            return;
        end
        text = '0;
        // Comment lines do not parse as four hex fields and are skipped
        while ($fgets(text, fd) != 0) begin
            if ($sscanf(text, "%h %h %h %h", f_op, f_addr, f_data, f_resp) == 4) begin
                op_q.push_back(f_op);
                addr_q.push_back(f_addr);
                data_q.push_back(f_data);
                resp_q.push_back(f_resp);
                if (f_op == 32'd3) n_ops += int'(f_addr);
                else if (f_op == 32'd4) n_ops += win_words;
                else if (f_op == 32'd5) stall_total += int'(f_addr);
                else n_ops++;
            end
            text = '0;
        end
        $fclose(fd);
        // Room for reset and the final drain on top of the per operation budget
        limit = n_ops * 40 + stall_total + 40;
    endtask

    task automatic issue_write(input string name, input logic [31:0] addr, input logic [31:0] data);
        axis_rd_resp_t e;
        @(negedge clock);
        rq_valid     = 1'b0;
        wr_valid     = 1'b1;
        wr_beat.dest = addr;
        wr_beat.data = data;
        @(posedge clock);
        while (!wr_ready) @(posedge clock);
        e = predict_read(addr);
        e.data = data;
        if (in_window(addr)) ref_mem[addr[5:2]] = data;
        exp_is_wr.push_back(1'b1);
        exp_rsp.push_back(e);
        exp_name.push_back(name);
    endtask

    task automatic issue_read(input string name, input logic [31:0] addr);
        @(negedge clock);
        wr_valid     = 1'b0;
        rq_valid     = 1'b1;
        rq_beat.data = addr;
        @(posedge clock);
        while (!rq_ready) @(posedge clock);
        exp_is_wr.push_back(1'b0);
        exp_rsp.push_back(predict_read(addr));
        exp_name.push_back(name);
    endtask

    // Op 1 write, 2 read, 3 random writes, 4 read every window word, 5 stall responses
    task automatic run_ops();
        axis_rd_resp_t pred;
        string         name;
        logic [31:0]   r_addr;
        logic [31:0]   r_data;
        for (int i = 0; i < op_q.size(); i++) begin
            name = $sformatf("line %0d", i + 1);
            pred = predict_read(addr_q[i]);
            if ((op_q[i] == 32'd1 && resp_q[i][1:0] != pred.resp) ||
                (op_q[i] == 32'd2 && (data_q[i] != pred.data || resp_q[i][1:0] != pred.resp))) begin
                other_errors++;
                $display("ERROR: %s of the input file disagrees with the reference memory", name);
            end
            case (op_q[i])
                32'd1: issue_write(name, addr_q[i], data_q[i]);
                32'd2: issue_read(name, addr_q[i]);
                32'd3: begin
                    for (int k = 0; k < int'(addr_q[i]); k++) begin
                        r_addr = win_base + ((32'($random(seed)) & 32'hF) << 2);
                        r_data = 32'($random(seed));
                        issue_write($sformatf("%s write %0d", name, k), r_addr, r_data);
                    end
                end
                32'd4: begin
                    for (int k = 0; k < win_words; k++) begin
                        issue_read($sformatf("%s read %0d", name, k), win_base + 32'(k * 4));
                    end
                end
                // Runs in the rising edge context, so the ready driver sees it at the next fall
                32'd5: stall_until = cycles + int'(addr_q[i]);
                default: begin
                    other_errors++;
                    $display("ERROR: %s has an unknown op code %0d", name, op_q[i]);
                end
            endcase
        end
    endtask

    always @(negedge clock) begin
        rsp_ready <= (cycles >= stall_until);
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("ERROR: timeout after %0d cycles with %0d commands outstanding",
                     cycles, exp_name.size());
            $display("Errors: read %0d, write %0d, other %0d", read_errors, write_errors,
                     other_errors + 1);
            $display("test failed");
            $finish;
        end
    end

    // Completions are sampled on the rising edge, before the DUT registers update
    always @(posedge clock) begin
        if (arst_n && exp_name.size() != 0 &&
            (bus_req.awvalid || bus_req.wvalid || bus_req.arvalid)) begin
            check_tie_off(exp_name[0], bus_req);
        end
        if (arst_n && rsp_valid && rsp_ready) begin
            if (exp_name.size() == 0 || exp_is_wr[0]) begin
                other_errors++;
                $display("ERROR: read response at cycle %0d while no read is next in order",
                         cycles);
            end else begin
                check_read(exp_name[0], exp_rsp[0], rsp_beat);
                void'(exp_is_wr.pop_front());
                void'(exp_rsp.pop_front());
                void'(exp_name.pop_front());
            end
        end
        if (arst_n && bus_req.bready && bus_rsp.bvalid) begin
            if (exp_name.size() == 0 || !exp_is_wr[0]) begin
                other_errors++;
                $display("ERROR: write response at cycle %0d while no write is next in order",
                         cycles);
            end else begin
                check_write_err(exp_name[0], exp_rsp[0].resp != OKAY, write_error);
                void'(exp_is_wr.pop_front());
                void'(exp_rsp.pop_front());
                void'(exp_name.pop_front());
            end
        end else if (write_error) begin
            other_errors++;
            $display("ERROR: write_error is high at cycle %0d outside a write response", cycles);
        end
    end

    initial begin
        for (int i = 0; i < win_words; i++) begin
            ref_mem[i] = '0;
        end
        load_input();
        repeat (5) begin
            @(posedge clock);
            check_quiet(1'b1);
        end
        @(negedge clock);
        arst_n = 1'b1;
        repeat (3) begin
            @(posedge clock);
            check_quiet(1'b0);
        end
        run_ops();
        @(negedge clock);
        wr_valid = 1'b0;
        rq_valid = 1'b0;
        while (exp_name.size() != 0) @(posedge clock);
        // A few spare cycles expose any duplicated response
        repeat (10) @(posedge clock);
        $display("Errors: read %0d, write %0d, other %0d", read_errors, write_errors, other_errors);
        if (read_errors + write_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: include/axis_bridge_consts.svh
/*
 * Bridge width and depth constants shared by the package and the FIFO.
 * The AXI-Lite data width must be a multiple of 8, because write strobes are derived from it.
 */
`ifndef AXIS_BRIDGE_CONSTS_SVH
`define AXIS_BRIDGE_CONSTS_SVH

// Byte address width on the AXI-Lite side and in the stream dest field
`define AXB_ADDR_W 32

// Data word width for streams and the bus
`define AXB_DATA_W 32

// Default number of buffered commands between merger and engine
`define AXB_FIFO_DEPTH 8

`endif

// File: rtl/axil_master_engine.sv
/*
 * Runs one command at a time as a single AXI-Lite write or read.
 * Write responses are not returned, a non-OKAY bresp only pulses write_error.
 * Protection bits are zero and every write uses all byte lanes.
 */
`timescale 1ns/1ps
`default_nettype none

module axil_master_engine (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  axis_bridge_pkg::bridge_cmd_t   cmd,
    output axis_bridge_pkg::axil_req_t     axil_out,
    input  axis_bridge_pkg::axil_rsp_t     axil_in,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output axis_bridge_pkg::axis_rd_resp_t resp,
    output logic                          write_error
);

    import axis_bridge_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_ADDR_DATA,
        ST_WR_RESP,
        ST_RD_ADDR,
        ST_RD_DATA,
        ST_RESP_HOLD
    } state_e;

    state_e        state;
    bridge_cmd_t   cmd_q;
    axis_rd_resp_t resp_q;
    // Set once the aw or w handshake of the current write has happened
    logic          aw_done;
    logic          w_done;
    logic          aw_hs;
    logic          w_hs;

    // New work is only taken when the bus side is completely quiet
    assign cmd_ready = (state == ST_IDLE);

    always_comb begin
        axil_out         = '0;
        axil_out.awaddr  = cmd_q.addr;
        axil_out.araddr  = cmd_q.addr;
        axil_out.wdata   = cmd_q.data;
        axil_out.wstrb   = '1;
        axil_out.awvalid = (state == ST_WR_ADDR_DATA) & ~aw_done;
        axil_out.wvalid  = (state == ST_WR_ADDR_DATA) & ~w_done;
        axil_out.bready  = (state == ST_WR_RESP);
        axil_out.arvalid = (state == ST_RD_ADDR);
        axil_out.rready  = (state == ST_RD_DATA);
    end

    assign aw_hs = axil_out.awvalid & axil_in.awready;
    assign w_hs  = axil_out.wvalid & axil_in.wready;

    assign resp_valid = (state == ST_RESP_HOLD);
    assign resp       = resp_q;

    // Pulse lands on the same cycle the write response is taken
    assign write_error = (state == ST_WR_RESP) & axil_in.bvalid & (axil_in.bresp != OKAY);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (cmd_valid) begin
                        state <= cmd.is_write ? ST_WR_ADDR_DATA : ST_RD_ADDR;
                    end
                end
                ST_WR_ADDR_DATA: begin
                    if (aw_hs) aw_done <= 1'b1;
                    if (w_hs) w_done <= 1'b1;
                    // The two channels may finish in either order or together
                    if ((aw_done | aw_hs) && (w_done | w_hs)) begin
                        state <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP: begin
                    if (axil_in.bvalid) state <= ST_IDLE;
                end
                ST_RD_ADDR: begin
                    if (axil_in.arready) state <= ST_RD_DATA;
                end
                ST_RD_DATA: begin
                    if (axil_in.rvalid) state <= ST_RESP_HOLD;
                end
                ST_RESP_HOLD: begin
                    // Stream back-pressure stalls the whole engine here
                    if (resp_ready) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command and read data are payload, captured without reset
    always_ff @(posedge clock) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q <= cmd;
        end
        if (state == ST_RD_DATA && axil_in.rvalid) begin
            resp_q.data <= axil_in.rdata;
            resp_q.resp <= axil_in.rresp;
        end
    end

    // A valid raised toward the bus or the response stream holds until its handshake
    a_aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
        axil_out.awvalid && !axil_in.awready |=> axil_out.awvalid);
    a_w_hold: assert property (@(posedge clock) disable iff (!arst_n)
        axil_out.wvalid && !axil_in.wready |=> axil_out.wvalid);
    a_ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
        axil_out.arvalid && !axil_in.arready |=> axil_out.arvalid);
    a_resp_hold: assert property (@(posedge clock) disable iff (!arst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

`default_nettype wire

// File: rtl/axis_bridge_pkg.sv
/*
 * Payload and channel types for the stream to AXI-Lite bridge.
 * The streams carry no sideband signals except dest, and the bus has no bursts.
 */
`default_nettype none
`include "axis_bridge_consts.svh"

package axis_bridge_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    // Write stream beat, dest holds the target bus address
    typedef struct packed {
        logic [`AXB_DATA_W-1:0] data;
        logic [`AXB_ADDR_W-1:0] dest;
    } axis_wr_t;

    // Read request beat, the address rides in the data field
    typedef struct packed {
        logic [`AXB_ADDR_W-1:0] data;
    } axis_rd_req_t;

    typedef struct packed {
        logic [`AXB_DATA_W-1:0] data;
        axil_resp_e             resp;
    } axis_rd_resp_t;

    // One tagged bus operation, data is unused for reads
    typedef struct packed {
        logic                   is_write;
        logic [`AXB_ADDR_W-1:0] addr;
        logic [`AXB_DATA_W-1:0] data;
    } bridge_cmd_t;

    // Signals driven by the AXI-Lite master
    typedef struct packed {
        logic                     awvalid;
        logic [`AXB_ADDR_W-1:0]   awaddr;
        logic [2:0]               awprot;
        logic                     wvalid;
        logic [`AXB_DATA_W-1:0]   wdata;
        logic [`AXB_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [`AXB_ADDR_W-1:0]   araddr;
        logic [2:0]               arprot;
        logic                     rready;
    } axil_req_t;

    // Signals driven by the AXI-Lite slave
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        axil_resp_e             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [`AXB_DATA_W-1:0] rdata;
        axil_resp_e             rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: rtl/axis_cmd_merge.sv
/*
 * Merges the write stream and the read-request stream into one command stream.
 * It is purely combinational and a pending write always beats a pending read.
 */
`timescale 1ns/1ps
`default_nettype none

module axis_cmd_merge (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        wr_valid,
    output logic                        wr_ready,
    input  axis_bridge_pkg::axis_wr_t    wr_data,
    input  logic                        rd_valid,
    output logic                        rd_ready,
    input  axis_bridge_pkg::axis_rd_req_t rd_data,
    output logic                        cmd_valid,
    input  logic                        cmd_ready,
    output axis_bridge_pkg::bridge_cmd_t cmd
);

    // A read only goes through when no write is waiting
    logic rd_sel;

    assign rd_sel = rd_valid & ~wr_valid;

    // The losing side sees ready low, so it keeps its beat for a later cycle
    assign rd_ready = cmd_ready & rd_sel;
    assign wr_ready = cmd_ready & ~rd_sel;

    assign cmd_valid = wr_valid | rd_valid;

    always_comb begin
        if (rd_sel) begin
            cmd.is_write = 1'b0;
            cmd.addr     = rd_data.data;
            // Reads carry no payload
            cmd.data     = '0;
        end else begin
            cmd.is_write = 1'b1;
            cmd.addr     = wr_data.dest;
            cmd.data     = wr_data.data;
        end
    end

    // A source that was held off keeps its beat, because the merger stores nothing
    a_wr_hold: assert property (@(posedge clock) disable iff (!arst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_data));
    a_rd_hold: assert property (@(posedge clock) disable iff (!arst_n)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data));

endmodule

`default_nettype wire

// File: rtl/axis_to_axil.sv
/*
 * Stream to AXI-Lite bridge, merger feeding a command FIFO feeding the bus engine.
 * Commands finish strictly in the order they were accepted.
 */
`timescale 1ns/1ps
`default_nettype none

module axis_to_axil (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          axis_write_valid,
    output logic                          axis_write_ready,
    input  axis_bridge_pkg::axis_wr_t      axis_write,
    input  logic                          axis_read_request_valid,
    output logic                          axis_read_request_ready,
    input  axis_bridge_pkg::axis_rd_req_t  axis_read_request,
    output logic                          axis_read_response_valid,
    input  logic                          axis_read_response_ready,
    output axis_bridge_pkg::axis_rd_resp_t axis_read_response,
    output axis_bridge_pkg::axil_req_t     axil_out,
    input  axis_bridge_pkg::axil_rsp_t     axil_in,
    output logic                          write_error
);

    import axis_bridge_pkg::*;

    // Merger to FIFO
    logic        merge_valid;
    logic        merge_ready;
    bridge_cmd_t merge_cmd;
    // FIFO to engine
    logic        fifo_valid;
    logic        fifo_ready;
    bridge_cmd_t fifo_cmd;

    axis_cmd_merge u_merge (
        .clock     (clock),
        .arst_n    (arst_n),
        .wr_valid  (axis_write_valid),
        .wr_ready  (axis_write_ready),
        .wr_data   (axis_write),
        .rd_valid  (axis_read_request_valid),
        .rd_ready  (axis_read_request_ready),
        .rd_data   (axis_read_request),
        .cmd_valid (merge_valid),
        .cmd_ready (merge_ready),
        .cmd       (merge_cmd)
    );

    stream_fifo #(
        .item_t (bridge_cmd_t)
    ) u_cmd_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (merge_valid),
        .in_ready  (merge_ready),
        .in_item   (merge_cmd),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_item  (fifo_cmd)
    );

    axil_master_engine u_engine (
        .clock       (clock),
        .arst_n      (arst_n),
        .cmd_valid   (fifo_valid),
        .cmd_ready   (fifo_ready),
        .cmd         (fifo_cmd),
        .axil_out    (axil_out),
        .axil_in     (axil_in),
        .resp_valid  (axis_read_response_valid),
        .resp_ready  (axis_read_response_ready),
        .resp        (axis_read_response),
        .write_error (write_error)
    );

endmodule

`default_nettype wire

// File: rtl/stream_fifo.sv
/*
 * Synchronous FIFO with valid/ready on both sides and a typed payload.
 * Output valid rises one cycle after a push, and a full FIFO takes a push only alongside a pop.
 */
`timescale 1ns/1ps
`default_nettype none
`include "axis_bridge_consts.svh"

module stream_fifo #(
    parameter type         item_t = logic [7:0],
    parameter int unsigned depth  = `AXB_FIFO_DEPTH
) (
    input  logic  clock,
    input  logic  arst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  item_t in_item,
    output logic  out_valid,
    input  logic  out_ready,
    output item_t out_item
);

    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

    item_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic [ptr_w:0]   count_next;
    logic             space_q;
    logic             push;
    logic             pop;

    assign out_valid = (count != '0);
    assign out_item  = mem[rd_ptr];
    assign pop       = out_valid & out_ready;

    // Room left after the last edge, or a slot freed by a pop in this cycle
    assign in_ready = space_q | pop;
    assign push     = in_valid & in_ready;

    always_comb begin
        count_next = count;
        case ({push, pop})
            2'b10: count_next = count + 1'b1;
            2'b01: count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            // Held low so no input is accepted during reset
            space_q <= 1'b0;
        end else begin
            count   <= count_next;
            space_q <= (count_next != (ptr_w+1)'(depth));
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Only the entries between the read and write pointers hold valid items
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    // A full FIFO must never take a push unless a slot drains in the same cycle
    a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
        (count == (ptr_w+1)'(depth)) && !pop |-> !push);

    // An empty FIFO has both pointers together, so no pop has run ahead of the pushes
    a_no_underflow: assert property (@(posedge clock) disable iff (!arst_n)
        (count == '0) |-> (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator and runs it from the project root.
# Exits 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module axis_to_axil_tb \
    --Mdir obj_dir -o axis_to_axil_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/axis_to_axil_sim 2>&1)"
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: vlog.f
+incdir+include
rtl/axis_bridge_pkg.sv
rtl/axis_cmd_merge.sv
rtl/stream_fifo.sv
rtl/axil_master_engine.sv
rtl/axis_to_axil.sv
dv/axil_mem_model.sv
dv/axis_to_axil_tb.sv
